// ==== design/bbc_params.svh ====
`ifndef BBC_PARAMS_SVH
`define BBC_PARAMS_SVH

// Processor bus
`define BBC_ADDR_W 16
`define BBC_DATA_W 8

// Video RAM address, 32 KB screen window in 15 bits
`define BBC_VADDR_W 15

// 32 MHz phase counter, one full turn per 1 MHz period
`define BBC_PHASE_W 5
`define BBC_PHASE_LAST 5'd31

`endif

// ==== design/bbc_bus_pkg.sv ====
`include "bbc_params.svh"

package bbc_bus_pkg;

	// Processor bus words
	typedef logic [`BBC_ADDR_W-1:0] bus_addr_t;
	typedef logic [`BBC_DATA_W-1:0] bus_data_t;

	// One region or device per address
	typedef enum logic [3:0]
	{
		DEV_RAM,
		DEV_PAGED,
		DEV_MOS,
		DEV_FRED,
		DEV_JIM,
		DEV_CRTC,
		DEV_ACIA,
		DEV_SERPROC,
		DEV_VIDPROC,
		DEV_ROMSEL,
		DEV_SYSVIA,
		DEV_USERVIA,
		DEV_FDC,
		DEV_ADLC,
		DEV_ADC,
		DEV_TUBE
	} dev_sel_e;

	// Processor cycle pacing
	typedef enum logic
	{
		CYC_FAST,
		CYC_STRETCH
	} cyc_state_e;

endpackage

// ==== design/bbc_video_pkg.sv ====
`include "bbc_params.svh"

package bbc_video_pkg;

	// Screen start after wrap, from latch bits 5:4
	typedef enum logic [1:0]
	{
		WRAP_4000 = 2'b00,
		WRAP_6000 = 2'b01,
		WRAP_3000 = 2'b10,
		WRAP_5800 = 2'b11
	} wrap_mode_e;

	// Address into video RAM
	typedef logic [`BBC_VADDR_W-1:0] vid_addr_t;

endpackage

// ==== design/bbc_cycle_ctrl.sv ====
`timescale 1ns/1ns
`include "bbc_params.svh"

module bbc_cycle_ctrl
(
	input  logic CLK32M_I,
	input  logic rst_i,
	input  logic slow_access_i,
	output logic mhz4_clken_o,
	output logic mhz2_clken_o,
	output logic mhz1_clken_o,
	output logic cpu_clken_o,
	output logic mem_sync_o
);
	import bbc_bus_pkg::*;

	logic [`BBC_PHASE_W-1:0] phase;
	logic last_phase;
	logic mid_phase;
	logic mhz2;
	logic cpu_clk;
	cyc_state_e state;
	cyc_state_e state_next;

	// Free running 32 MHz phase, one turn per microsecond
	always_ff @(posedge CLK32M_I)
	begin
		if (rst_i)
		begin
			phase <= '0;
			state <= CYC_FAST;
		end
		else
		begin
			if (last_phase)
				phase <= '0;
			else
				phase <= phase + 1'b1;
			state <= state_next;
		end
	end

	assign last_phase = (phase == `BBC_PHASE_LAST);
	// Halfway point, where a 2 MHz cycle would normally end
	assign mid_phase = (phase == (`BBC_PHASE_LAST >> 1));

	assign mhz2 = &phase[3:0];

	// Slow peripherals hold the processor until the 1 MHz edge
	always_comb
	begin
		state_next = state;
		cpu_clk = 1'b0;
		case (state)
			CYC_FAST:
			begin
				if (mid_phase && slow_access_i)
					state_next = CYC_STRETCH;
				else
					cpu_clk = mhz2;
			end
			CYC_STRETCH:
			begin
				if (last_phase)
				begin
					cpu_clk = 1'b1;
					state_next = CYC_FAST;
				end
			end
		endcase
	end

	assign mhz4_clken_o = &phase[2:0];
	assign mhz2_clken_o = mhz2;
	assign mhz1_clken_o = last_phase;
	assign cpu_clken_o = cpu_clk;

	// Memory controller runs in step with the processor
	assign mem_sync_o = cpu_clk;

endmodule

// ==== design/bbc_addr_decode.sv ====
`timescale 1ns/1ns

module bbc_addr_decode
(
	input  bbc_bus_pkg::bus_addr_t cpu_a_i,
	input  logic                   cpu_r_nw_i,
	input  logic                   rst_i,
	input  logic [3:0]             romsel_i,
	input  bbc_bus_pkg::bus_data_t mem_di_i,
	input  bbc_bus_pkg::bus_data_t crtc_do_i,
	input  bbc_bus_pkg::bus_data_t sys_via_do_i,
	input  bbc_bus_pkg::bus_data_t user_via_do_i,
	input  bbc_bus_pkg::bus_data_t adc_do_i,
	input  logic                   sys_via_irq_i,
	input  logic                   user_via_irq_i,
	output bbc_bus_pkg::dev_sel_e  dev_sel_o,
	output logic                   slow_access_o,
	output bbc_bus_pkg::bus_data_t cpu_di_o,
	output logic                   mem_we_o,
	output logic                   cpu_irq_n_o
);
	import bbc_bus_pkg::*;

	dev_sel_e sel;
	dev_sel_e sheila_sel;
	logic ram_write;

	// SHEILA page, FE00 to FEFF
	always_comb
	begin
		casez (cpu_a_i[7:0])
			8'b0000_0???: sheila_sel = DEV_CRTC;
			8'b0000_1???: sheila_sel = DEV_ACIA;
			8'b0001_????: sheila_sel = DEV_SERPROC;
			8'b0010_????: sheila_sel = DEV_VIDPROC;
			8'b0011_????: sheila_sel = DEV_ROMSEL;
			8'b010?_????: sheila_sel = DEV_SYSVIA;
			8'b011?_????: sheila_sel = DEV_USERVIA;
			8'b100?_????: sheila_sel = DEV_FDC;
			8'b101?_????: sheila_sel = DEV_ADLC;
			8'b110?_????: sheila_sel = DEV_ADC;
			default:      sheila_sel = DEV_TUBE;
		endcase
	end

	// Top level memory map
	always_comb
	begin
		if (!cpu_a_i[15])
			sel = DEV_RAM;
		else if (!cpu_a_i[14])
			sel = DEV_PAGED;
		else if (cpu_a_i[15:8] == 8'hfc)
			sel = DEV_FRED;
		else if (cpu_a_i[15:8] == 8'hfd)
			sel = DEV_JIM;
		else if (cpu_a_i[15:8] == 8'hfe)
			sel = sheila_sel;
		else
			sel = DEV_MOS;
	end

	// Devices on the 1 MHz bus
	always_comb
	begin
		case (sel)
			DEV_FRED, DEV_JIM, DEV_ACIA, DEV_SERPROC, DEV_SYSVIA,
			DEV_USERVIA, DEV_FDC, DEV_ADLC, DEV_ADC:
				slow_access_o = 1'b1;
			default:
				slow_access_o = 1'b0;
		endcase
	end

	// Read data back to the processor
	always_comb
	begin
		case (sel)
			DEV_RAM, DEV_PAGED, DEV_MOS: cpu_di_o = mem_di_i;
			DEV_CRTC:                    cpu_di_o = crtc_do_i;
			// ACIA stub reports transmit empty
			DEV_ACIA:                    cpu_di_o = 8'h02;
			DEV_SYSVIA:                  cpu_di_o = sys_via_do_i;
			DEV_USERVIA:                 cpu_di_o = user_via_do_i;
			DEV_ADC:                     cpu_di_o = adc_do_i;
			default:                     cpu_di_o = 8'h00;
		endcase
	end

	// Sideways RAM only in banks 0 to 7
	assign ram_write = (sel == DEV_RAM) || ((sel == DEV_PAGED) && !romsel_i[3]);
	assign mem_we_o = !rst_i && !cpu_r_nw_i && ram_write;

	// Either VIA pulls the shared IRQ line low
	assign cpu_irq_n_o = !(sys_via_irq_i || user_via_irq_i);

	assign dev_sel_o = sel;

endmodule

// ==== design/bbc_sys_latch.sv ====
`timescale 1ns/1ns

module bbc_sys_latch
(
	input  logic                     CLK32M_I,
	input  logic                     rst_i,
	input  bbc_bus_pkg::dev_sel_e    dev_sel_i,
	input  logic                     cpu_r_nw_i,
	input  logic                     cpu_clken_i,
	input  bbc_bus_pkg::bus_data_t   cpu_do_i,
	input  logic [3:0]               sys_pb_i,
	output logic [3:0]               romsel_o,
	output bbc_video_pkg::wrap_mode_e wrap_mode_o,
	output logic                     sound_we_n_o,
	output logic                     speech_wr_n_o,
	output logic                     speech_rd_n_o,
	output logic                     kb_autoscan_n_o,
	output logic                     caps_led_n_o,
	output logic                     shift_led_n_o
);
	import bbc_bus_pkg::*;
	import bbc_video_pkg::*;

	logic [3:0] romsel;
	logic [7:0] latch;

	always_ff @(posedge CLK32M_I)
	begin
		if (rst_i)
		begin
			romsel <= '0;
			latch <= '0;
		end
		else
		begin
			// PB2..0 pick the bit, PB3 is its new value
			latch[sys_pb_i[2:0]] <= sys_pb_i[3];
			if (dev_sel_i == DEV_ROMSEL && !cpu_r_nw_i && cpu_clken_i)
				romsel <= cpu_do_i[3:0];
		end
	end

	assign romsel_o = romsel;

	assign sound_we_n_o = latch[0];
	assign speech_wr_n_o = latch[1];
	assign speech_rd_n_o = latch[2];
	assign kb_autoscan_n_o = latch[3];
	// Screen size for hardware scroll wrap
	assign wrap_mode_o = wrap_mode_e'(latch[5:4]);
	assign caps_led_n_o = latch[6];
	assign shift_led_n_o = latch[7];

endmodule

// ==== design/bbc_display_addr.sv ====
`timescale 1ns/1ns

module bbc_display_addr
(
	input  logic [13:0]               crtc_ma_i,
	input  logic [2:0]                crtc_ra_i,
	input  bbc_video_pkg::wrap_mode_e wrap_mode_i,
	output bbc_video_pkg::vid_addr_t  vid_adr_o
);
	import bbc_video_pkg::*;

	logic [3:0] offset;
	logic [3:0] nibble;

	// Offset that folds the screen back below 8000
	always_comb
	begin
		case (wrap_mode_i)
			WRAP_4000: offset = 4'd8;
			WRAP_6000: offset = 4'd12;
			WRAP_3000: offset = 4'd6;
			WRAP_5800: offset = 4'd11;
		endcase
	end

	// MA12 marks an address past the top of memory
	always_comb
	begin
		if (crtc_ma_i[12])
			nibble = crtc_ma_i[11:8] + offset;
		else
			nibble = crtc_ma_i[11:8];
	end

	// Teletext screen lives at 3C00 or 7C00, one byte per character
	always_comb
	begin
		if (crtc_ma_i[13])
			vid_adr_o = {nibble[3], 4'b1111, crtc_ma_i[9:0]};
		else
			vid_adr_o = {nibble, crtc_ma_i[7:0], crtc_ra_i};
	end

endmodule

// ==== design/bbc_glue.sv ====
`timescale 1ns/1ns

module bbc_glue
(
	input  logic                      CLK32M_I,
	input  logic                      rst_i,
	input  bbc_bus_pkg::bus_addr_t    cpu_a_i,
	input  bbc_bus_pkg::bus_data_t    cpu_do_i,
	input  logic                      cpu_r_nw_i,
	output bbc_bus_pkg::bus_data_t    cpu_di_o,
	output logic                      cpu_irq_n_o,
	output bbc_bus_pkg::bus_addr_t    mem_adr_o,
	output bbc_bus_pkg::bus_data_t    mem_do_o,
	input  bbc_bus_pkg::bus_data_t    mem_di_i,
	output logic                      mem_we_o,
	output logic                      mem_sync_o,
	output logic [3:0]                romsel_o,
	input  bbc_bus_pkg::bus_data_t    crtc_do_i,
	input  logic [13:0]               crtc_ma_i,
	input  logic [2:0]                crtc_ra_i,
	output bbc_video_pkg::vid_addr_t  vid_adr_o,
	input  bbc_bus_pkg::bus_data_t    sys_via_do_i,
	input  bbc_bus_pkg::bus_data_t    user_via_do_i,
	input  bbc_bus_pkg::bus_data_t    adc_do_i,
	input  logic                      sys_via_irq_i,
	input  logic                      user_via_irq_i,
	input  logic [3:0]                sys_pb_i,
	output logic                      sound_we_n_o,
	output logic                      speech_wr_n_o,
	output logic                      speech_rd_n_o,
	output logic                      kb_autoscan_n_o,
	output logic                      caps_led_n_o,
	output logic                      shift_led_n_o,
	output bbc_bus_pkg::dev_sel_e     dev_sel_o,
	output logic                      mhz4_clken_o,
	output logic                      mhz2_clken_o,
	output logic                      mhz1_clken_o,
	output logic                      cpu_clken_o
);
	import bbc_video_pkg::*;

	logic slow_access;
	wrap_mode_e wrap_mode;

	bbc_cycle_ctrl u_cycle_ctrl
	(
		.CLK32M_I      (CLK32M_I),
		.rst_i         (rst_i),
		.slow_access_i (slow_access),
		.mhz4_clken_o  (mhz4_clken_o),
		.mhz2_clken_o  (mhz2_clken_o),
		.mhz1_clken_o  (mhz1_clken_o),
		.cpu_clken_o   (cpu_clken_o),
		.mem_sync_o    (mem_sync_o)
	);

	bbc_addr_decode u_addr_decode
	(
		.cpu_a_i        (cpu_a_i),
		.cpu_r_nw_i     (cpu_r_nw_i),
		.rst_i          (rst_i),
		.romsel_i       (romsel_o),
		.mem_di_i       (mem_di_i),
		.crtc_do_i      (crtc_do_i),
		.sys_via_do_i   (sys_via_do_i),
		.user_via_do_i  (user_via_do_i),
		.adc_do_i       (adc_do_i),
		.sys_via_irq_i  (sys_via_irq_i),
		.user_via_irq_i (user_via_irq_i),
		.dev_sel_o      (dev_sel_o),
		.slow_access_o  (slow_access),
		.cpu_di_o       (cpu_di_o),
		.mem_we_o       (mem_we_o),
		.cpu_irq_n_o    (cpu_irq_n_o)
	);

	bbc_sys_latch u_sys_latch
	(
		.CLK32M_I        (CLK32M_I),
		.rst_i           (rst_i),
		.dev_sel_i       (dev_sel_o),
		.cpu_r_nw_i      (cpu_r_nw_i),
		.cpu_clken_i     (cpu_clken_o),
		.cpu_do_i        (cpu_do_i),
		.sys_pb_i        (sys_pb_i),
		.romsel_o        (romsel_o),
		.wrap_mode_o     (wrap_mode),
		.sound_we_n_o    (sound_we_n_o),
		.speech_wr_n_o   (speech_wr_n_o),
		.speech_rd_n_o   (speech_rd_n_o),
		.kb_autoscan_n_o (kb_autoscan_n_o),
		.caps_led_n_o    (caps_led_n_o),
		.shift_led_n_o   (shift_led_n_o)
	);

	bbc_display_addr u_display_addr
	(
		.crtc_ma_i   (crtc_ma_i),
		.crtc_ra_i   (crtc_ra_i),
		.wrap_mode_i (wrap_mode),
		.vid_adr_o   (vid_adr_o)
	);

	// Memory sees the processor bus directly
	assign mem_adr_o = cpu_a_i;
	assign mem_do_o = cpu_do_i;

endmodule

// ==== tb/bbc_glue_chk.sv ====
`timescale 1ns/1ns

module bbc_glue_chk
(
	input logic CLK32M_I,
	input logic rst_i,
	input logic mhz4_clken_i,
	input logic mhz2_clken_i,
	input logic mhz1_clken_i,
	input logic cpu_clken_i
);
	// Set once any property fails
	logic assert_failed = 1'b0;

	// Phase restarts at zero, so no enable right after reset
	a_quiet_after_reset: assert property (@(posedge CLK32M_I)
		rst_i |=> !(mhz4_clken_i || mhz2_clken_i || mhz1_clken_i || cpu_clken_i))
	else
	begin
		$error("Clock enable active in the cycle after reset");
		assert_failed = 1'b1;
	end

	// Slower enables are subsets of the faster ones
	a_enables_nested: assert property (@(posedge CLK32M_I) disable iff (rst_i)
		(mhz1_clken_i |-> mhz2_clken_i) and (mhz2_clken_i |-> mhz4_clken_i))
	else
	begin
		$error("Clock enables are not nested");
		assert_failed = 1'b1;
	end

	a_cpu_on_mhz2: assert property (@(posedge CLK32M_I) disable iff (rst_i)
		cpu_clken_i |-> mhz2_clken_i)
	else
	begin
		$error("Processor enable outside a 2 MHz edge");
		assert_failed = 1'b1;
	end

endmodule

// ==== tb/bbc_glue_tb.sv ====
`timescale 1ns/1ns

module bbc_glue_tb;
	import bbc_bus_pkg::*;
	import bbc_video_pkg::*;

	// About three times the length of the tests
	localparam int CYCLE_LIMIT = 10000;

	logic CLK32M_I = 1'b0;
	logic rst_i = 1'b1;
	bus_addr_t cpu_a_i = '0;
	bus_data_t cpu_do_i = '0;
	logic cpu_r_nw_i = 1'b1;
	bus_data_t mem_di_i = '0;
	bus_data_t crtc_do_i = '0;
	logic [13:0] crtc_ma_i = '0;
	logic [2:0] crtc_ra_i = '0;
	bus_data_t sys_via_do_i = '0;
	bus_data_t user_via_do_i = '0;
	bus_data_t adc_do_i = '0;
	logic sys_via_irq_i = 1'b0;
	logic user_via_irq_i = 1'b0;
	logic [3:0] sys_pb_i = '0;

	bus_data_t cpu_di_o, mem_do_o;
	bus_addr_t mem_adr_o;
	logic cpu_irq_n_o, mem_we_o, mem_sync_o;
	logic [3:0] romsel_o;
	vid_addr_t vid_adr_o;
	logic sound_we_n_o, speech_wr_n_o, speech_rd_n_o;
	logic kb_autoscan_n_o, caps_led_n_o, shift_led_n_o;
	dev_sel_e dev_sel_o;
	logic mhz4_clken_o, mhz2_clken_o, mhz1_clken_o, cpu_clken_o;

	logic [3:0] exp_romsel = '0;
	logic [7:0] exp_latch = '0;
	integer seed;
	int cycle_count = 0;

	bind bbc_cycle_ctrl bbc_glue_chk u_chk
	(
		.CLK32M_I     (CLK32M_I),
		.rst_i        (rst_i),
		.mhz4_clken_i (mhz4_clken_o),
		.mhz2_clken_i (mhz2_clken_o),
		.mhz1_clken_i (mhz1_clken_o),
		.cpu_clken_i  (cpu_clken_o)
	);

	bbc_glue uut (.*);

	always #10 CLK32M_I = ~CLK32M_I;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		abort_run($sformatf("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
	endtask

	function automatic dev_sel_e decode_device(input bus_addr_t a);
		logic [7:0] lo;
		lo = a[7:0];
		if (a[15:8] != 8'hfe)
			return (a < 16'h8000) ? DEV_RAM :
				(a < 16'hc000) ? DEV_PAGED :
				(a[15:8] == 8'hfc) ? DEV_FRED :
				(a[15:8] == 8'hfd) ? DEV_JIM : DEV_MOS;
		// SHEILA page by offset range
		return (lo < 8'h08) ? DEV_CRTC :
			(lo < 8'h10) ? DEV_ACIA :
			(lo < 8'h20) ? DEV_SERPROC :
			(lo < 8'h30) ? DEV_VIDPROC :
			(lo < 8'h40) ? DEV_ROMSEL :
			(lo < 8'h60) ? DEV_SYSVIA :
			(lo < 8'h80) ? DEV_USERVIA :
			(lo < 8'ha0) ? DEV_FDC :
			(lo < 8'hc0) ? DEV_ADLC :
			(lo < 8'he0) ? DEV_ADC : DEV_TUBE;
	endfunction

	function automatic bus_data_t select_read_byte(input dev_sel_e d);
		case (d)
			DEV_RAM, DEV_PAGED, DEV_MOS: return mem_di_i;
			DEV_CRTC:                    return crtc_do_i;
			DEV_ACIA:                    return 8'h02;
			DEV_SYSVIA:                  return sys_via_do_i;
			DEV_USERVIA:                 return user_via_do_i;
			DEV_ADC:                     return adc_do_i;
			default:                     return 8'h00;
		endcase
	endfunction

	function automatic logic write_enable_for(input logic rst, input logic r_nw,
		input dev_sel_e d, input logic [3:0] bank);
		return !rst && !r_nw && (d == DEV_RAM || (d == DEV_PAGED && bank < 4'd8));
	endfunction

	function automatic vid_addr_t translate_video_addr(input logic [13:0] ma,
		input logic [2:0] ra, input logic [1:0] mode);
		logic [4:0] add;
		logic [4:0] sum;
		add = (mode == 2'b00) ? 5'd8 : (mode == 2'b01) ? 5'd12 : (mode == 2'b10) ? 5'd6 : 5'd11;
		// Only addresses past the top of memory wrap
		sum = {1'b0, ma[11:8]} + (ma[12] ? add : 5'd0);
		if (ma[13])
			return {sum[3], 4'hf, ma[9:0]};
		return {sum[3:0], ma[7:0], ra};
	endfunction

	always @(posedge CLK32M_I)
	begin
		dev_sel_e exp_dev;
		logic exp_irq_n;
		logic exp_we;
		if (!rst_i)
		begin
			exp_dev = decode_device(cpu_a_i);
			exp_irq_n = (sys_via_irq_i || user_via_irq_i) ? 1'b0 : 1'b1;
			exp_we = write_enable_for(rst_i, cpu_r_nw_i, exp_dev, exp_romsel);
			assert (dev_sel_o == exp_dev)
			else report_mismatch("dev_sel_o", 32'(dev_sel_o), 32'(exp_dev));
			assert (cpu_di_o == select_read_byte(exp_dev))
			else report_mismatch("cpu_di_o", 32'(cpu_di_o), 32'(select_read_byte(exp_dev)));
			assert (cpu_irq_n_o == exp_irq_n)
			else report_mismatch("cpu_irq_n_o", 32'(cpu_irq_n_o), 32'(exp_irq_n));
			assert ({mem_adr_o, mem_do_o} == {cpu_a_i, cpu_do_i})
			else report_mismatch("mem_adr_o and mem_do_o", {8'h0, mem_adr_o, mem_do_o},
				{8'h0, cpu_a_i, cpu_do_i});
			assert (mem_we_o == exp_we)
			else report_mismatch("mem_we_o", 32'(mem_we_o), 32'(exp_we));
			assert (romsel_o == exp_romsel)
			else report_mismatch("romsel_o", 32'(romsel_o), 32'(exp_romsel));
			assert (vid_adr_o == translate_video_addr(crtc_ma_i, crtc_ra_i, exp_latch[5:4]))
			else report_mismatch("vid_adr_o", 32'(vid_adr_o),
				32'(translate_video_addr(crtc_ma_i, crtc_ra_i, exp_latch[5:4])));
			assert (!uut.u_cycle_ctrl.u_chk.assert_failed)
			else abort_run("A property on the clock enables failed");
		end
	end

	always @(posedge CLK32M_I)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			abort_run("Timeout: the tests ran past the cycle limit");
	end

	// Intervals of the enables and mem_sync_o over eight 1 MHz periods
	task automatic check_pacing(input int cpu_gap, input logic slow);
		int last[5];
		int gap[5];
		string names[5];
		logic [4:0] hit;
		gap = '{8, 16, 32, cpu_gap, cpu_gap};
		last = '{-1, -1, -1, -1, -1};
		names = '{"mhz4_clken_o", "mhz2_clken_o", "mhz1_clken_o", "cpu_clken_o",
			"mem_sync_o"};
		repeat (32) @(posedge CLK32M_I);
		for (int n = 0; n < 256; n++)
		begin
			@(posedge CLK32M_I);
			hit = {mem_sync_o, cpu_clken_o, mhz1_clken_o, mhz2_clken_o, mhz4_clken_o};
			for (int k = 0; k < 5; k++)
			begin
				if (hit[k])
				begin
					if (last[k] >= 0)
					begin
						assert (n - last[k] == gap[k])
						else report_mismatch({"interval of ", names[k]}, n - last[k], gap[k]);
					end
					last[k] = n;
				end
				else
				begin
					// A missing pulse shows as a gap grown too long
					assert (n - last[k] < gap[k])
					else report_mismatch({"interval of ", names[k]}, n - last[k], gap[k]);
				end
			end
			if (slow && (hit[3] || hit[4]))
			begin
				assert (hit[2])
				else abort_run("Processor or memory enable pulsed away from the 1 MHz edge");
			end
			if (hit[4])
			begin
				assert (hit[1])
				else abort_run("mem_sync_o pulsed away from a 2 MHz edge");
			end
		end
	endtask

	task automatic drive_random_bus();
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		r0 = $random(seed);
		r1 = $random(seed);
		r2 = $random(seed);
		@(negedge CLK32M_I);
		cpu_a_i = r0[15:0];
		// Half the addresses land in FC00 to FFFF
		if (r0[16])
			cpu_a_i[15:10] = 6'h3f;
		// Reads and writes mixed, ROMSEL only ever read here
		cpu_r_nw_i = r2[27] || (cpu_a_i[15:4] == 12'hfe3);
		cpu_do_i = r0[31:24];
		mem_di_i = r1[7:0];
		crtc_do_i = r1[15:8];
		sys_via_do_i = r1[23:16];
		user_via_do_i = r1[31:24];
		adc_do_i = r2[7:0];
		sys_via_irq_i = r2[8];
		user_via_irq_i = r2[9];
		crtc_ma_i = r2[23:10];
		crtc_ra_i = r2[26:24];
	endtask

	task automatic romsel_gates_paged(input logic [3:0] bank);
		logic [31:0] rnd;
		logic seen;
		int waited;
		rnd = $random(seed);
		seen = 1'b0;
		waited = 0;
		@(negedge CLK32M_I);
		cpu_a_i = {12'hfe3, rnd[3:0]};
		cpu_do_i = {rnd[7:4], bank};
		cpu_r_nw_i = 1'b0;
		// Register loads on the edge carrying the processor enable
		while (!seen && waited < 64)
		begin
			@(posedge CLK32M_I);
			seen = cpu_clken_o;
			waited++;
		end
		assert (seen)
		else abort_run("The ROMSEL write never saw a cpu_clken_o pulse");
		@(negedge CLK32M_I);
		exp_romsel = bank;
		cpu_a_i = {2'b10, rnd[21:8]};
		@(negedge CLK32M_I);
		cpu_r_nw_i = 1'b1;
	endtask

	task automatic set_latch_bit(input logic [2:0] bit_num, input logic value);
		logic [7:0] seen;
		@(negedge CLK32M_I);
		sys_pb_i = {value, bit_num};
		@(posedge CLK32M_I);
		@(negedge CLK32M_I);
		// PB3 lands in the addressed bit on the clock in between
		exp_latch[bit_num] = value;
		seen = {shift_led_n_o, caps_led_n_o, uut.wrap_mode, kb_autoscan_n_o,
			speech_rd_n_o, speech_wr_n_o, sound_we_n_o};
		assert (seen == exp_latch)
		else report_mismatch($sformatf("latch after bit %0d", bit_num), 32'(seen),
			32'(exp_latch));
	endtask

	initial
	begin
		seed = 32'h719f_8eed;
		repeat (2) @(posedge CLK32M_I);
		@(negedge CLK32M_I);
		rst_i = 1'b0;
		cpu_a_i = 16'h2000;
		check_pacing(16, 1'b0);
		@(negedge CLK32M_I);
		cpu_a_i = 16'hfe40;
		check_pacing(32, 1'b1);
		repeat (2000) drive_random_bus();
		romsel_gates_paged(4'h5);
		romsel_gates_paged(4'hb);
		romsel_gates_paged(4'h0);
		romsel_gates_paged(4'he);
		for (int b = 0; b < 8; b++)
		begin
			set_latch_bit(3'(b), 1'b1);
			set_latch_bit(3'(b), 1'b0);
		end
		// Every screen wrap mode through latch bits 5:4
		for (int m = 0; m < 4; m++)
		begin
			set_latch_bit(3'd4, m[0]);
			set_latch_bit(3'd5, m[1]);
			repeat (200) drive_random_bus();
		end
		@(negedge CLK32M_I);
		if (uut.u_cycle_ctrl.u_chk.assert_failed)
			abort_run("A property on the clock enables failed");
		else
		begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

// ==== build.f ====
+incdir+design
design/bbc_bus_pkg.sv
design/bbc_video_pkg.sv
design/bbc_cycle_ctrl.sv
design/bbc_addr_decode.sv
design/bbc_sys_latch.sv
design/bbc_display_addr.sv
design/bbc_glue.sv
tb/bbc_glue_chk.sv
tb/bbc_glue_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = bbc_glue_tb
FILELIST   = build.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
RUN_FLAGS  = +verilator+error+limit+10
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
